/* list.f */
+incdir+.
game_pkg.sv
geom_pkg.sv
level_sequencer.sv
level_rom.sv
exit_marker.sv
map_top.sv
map_assert.sv
map_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= map_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "All tests passed!" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* map_tb.sv */
`default_nettype none
`timescale 1ns/1ps

`include "map_defs.svh"

module map_tb;
    import game_pkg::*;
    import geom_pkg::*;

    localparam int NUM_STEPS  = 14;
    localparam int NUM_PROBES = 8;
    localparam int NUM_RANDOM = 24;
    localparam int TIMEOUT    = 50;

    logic               Clk;
    logic               rst_n;
    logic               restart;
    logic               level_done;
    logic [`BOSS_W-1:0] boss_counter;
    coord_t             draw_x, draw_y;
    block_idx_t         block_idx;
    coord_t             spawn_x, spawn_y, bullet_x, bullet_y;
    coord_t             block_x, block_y, block_w, block_h;
    logic               block_used;
    coord_t             exit_x_addr, exit_y_addr;
    logic               is_exit;
    level_idx_t         level_idx;
    logic               update;
    logic               win;
    integer             seed;

    // Level_done applied each step, with the outputs expected one clock later.
    bit         step_done   [NUM_STEPS] = '{1, 1, 0, 0, 1, 1, 0, 1, 0, 1, 0, 1, 0, 1};
    level_idx_t step_level  [NUM_STEPS] = '{0, 0, 0, 0, 1, 1, 1, 2, 2, 3, 3, 3, 3, 3};
    bit         step_update [NUM_STEPS] = '{1, 1, 0, 0, 1, 1, 0, 1, 0, 1, 0, 0, 0, 0};
    bit         step_win    [NUM_STEPS] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1, 1, 1};

    // Marker corners, then one pixel outside each edge.
    int probe_dx [NUM_PROBES] = '{0, 16, 0, 16, -1, 17, 0, 0};
    int probe_dy [NUM_PROBES] = '{0, 0, 23, 23, 0, 0, -1, 24};

    int ref_spawn_x  [4] = '{20, 20, 30, 20};
    int ref_spawn_y  [4] = '{380, 380, 300, 380};
    int ref_bullet_x [4] = '{20, 20, 600, 20};
    int ref_bullet_y [4] = '{380, 380, 300, 380};
    int ref_exit_x   [4] = '{620, 620, 600, 330};
    int ref_exit_y   [4] = '{310, 40, 375, 450};
    int ref_blk      [4][21][4];  // Columns x, y, w and h. Entries past 16 stay zero.
    bit ref_used     [4][21];

    map_top uut (.*);

    bind level_sequencer map_assert u_assert (
        .Clk       (Clk),
        .rst_n     (rst_n),
        .restart   (restart),
        .level_idx (level_idx),
        .update    (update),
        .win       (win)
    );

    initial
    begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "Simulation stopped on error.");
    endtask

    task automatic check_level(input string name, input level_idx_t exp, input level_idx_t act);
        if (act !== exp)
            stop_on_error($sformatf("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_coord(input string name, input coord_t exp, input coord_t act);
        if (act !== exp)
            stop_on_error($sformatf("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_on_error($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic verify_sequencer(input string name, input level_idx_t lvl,
                                    input logic exp_update, input logic exp_win);
        check_level({name, " level_idx"}, lvl, level_idx);
        check_bit({name, " update"}, exp_update, update);
        check_bit({name, " win"}, exp_win, win);
    endtask

    task automatic next_drive();
        @(posedge Clk);
        #1;
    endtask

    task automatic wait_level(input level_idx_t target);
        int cycles;
        cycles = 0;
        while (level_idx !== target)
        begin
            next_drive();
            cycles++;
            if (cycles > TIMEOUT)
                stop_on_error($sformatf("Timed out waiting for level %0d.", target));
        end
    endtask

    task automatic advance_level(input level_idx_t target);
        next_drive();
        level_done = 1'b0;  // Arms the next rising level_done.
        next_drive();
        level_done = 1'b1;
        wait_level(target);
    endtask

    task automatic pulse_restart();
        next_drive();
        restart = 1'b1;
        next_drive();
        restart = 1'b0;
    endtask

    task automatic set_block(input int lvl, input int idx, input int x, input int y,
                             input int w, input int h);
        ref_used[lvl][idx]   = 1'b1;
        ref_blk[lvl][idx][0] = x;
        ref_blk[lvl][idx][1] = y;
        ref_blk[lvl][idx][2] = w;
        ref_blk[lvl][idx][3] = h;
    endtask

    task automatic load_blocks();
        set_block(0, 1, 480, 340, 160, 140);
        set_block(0, 2, 320, 360, 160, 120);
        set_block(0, 3, 160, 380, 160, 100);
        set_block(0, 4, 0, 400, 160, 80);
        set_block(1, 0, 0, 0, 640, 20);
        set_block(1, 1, 0, 20, 20, 280);
        set_block(1, 2, 280, 60, 240, 20);
        set_block(1, 3, 140, 80, 120, 20);
        set_block(1, 4, 560, 80, 100, 20);
        set_block(1, 5, 620, 100, 20, 380);
        set_block(1, 6, 20, 160, 60, 60);
        set_block(1, 7, 80, 160, 180, 100);
        set_block(1, 8, 500, 220, 100, 20);
        set_block(1, 9, 260, 240, 240, 20);
        set_block(1, 10, 540, 320, 80, 160);
        set_block(1, 11, 0, 340, 140, 20);
        set_block(1, 12, 220, 340, 80, 100);
        set_block(1, 13, 400, 380, 100, 20);
        set_block(1, 14, 0, 440, 300, 40);
        set_block(2, 0, 100, 100, 150, 40);
        set_block(2, 1, 100, 200, 150, 40);
        set_block(2, 2, 100, 300, 150, 40);
        set_block(2, 3, 300, 200, 150, 40);
        set_block(2, 4, 0, 400, 640, 80);
        set_block(3, 0, 160, 360, 320, 40);
        set_block(3, 1, 240, 320, 160, 40);
        set_block(3, 2, 300, 280, 40, 40);
        set_block(3, 4, 0, 400, 640, 80);
    endtask

    // Visible on levels 0 and 1, on level 2 once the boss gate opens, never on level 3.
    // The draw point must also lie inside the marker.
    function automatic logic marker_hit(input int lvl, input int boss,
                                        input int ox, input int oy);
        return (lvl != 3) && ((lvl != 2) || (boss >= `BOSS_GATE)) &&
               (ox >= 0) && (ox < `MARKER_W) && (oy >= 0) && (oy < `MARKER_H);
    endfunction

    task automatic test_level(input int lvl);
        string tag;
        int    i;
        tag = $sformatf("level %0d", lvl);
        check_coord({tag, " spawn_x"}, coord_t'(ref_spawn_x[lvl]), spawn_x);
        check_coord({tag, " spawn_y"}, coord_t'(ref_spawn_y[lvl]), spawn_y);
        check_coord({tag, " bullet_x"}, coord_t'(ref_bullet_x[lvl]), bullet_x);
        check_coord({tag, " bullet_y"}, coord_t'(ref_bullet_y[lvl]), bullet_y);
        for (i = 0; i <= 20; i++)
        begin
            next_drive();
            block_idx = block_idx_t'(i);
            #2;
            tag = $sformatf("level %0d block %0d", lvl, i);
            check_bit({tag, " used"}, ref_used[lvl][i], block_used);
            check_coord({tag, " x"}, coord_t'(ref_blk[lvl][i][0]), block_x);
            check_coord({tag, " y"}, coord_t'(ref_blk[lvl][i][1]), block_y);
            check_coord({tag, " w"}, coord_t'(ref_blk[lvl][i][2]), block_w);
            check_coord({tag, " h"}, coord_t'(ref_blk[lvl][i][3]), block_h);
        end
    endtask

    task automatic probe_marker(input int lvl, input int boss);
        string tag;
        int    n;
        int    r;
        int    ex;
        int    ey;
        int    ox;
        int    oy;
        ex = ref_exit_x[lvl];
        ey = ref_exit_y[lvl];
        for (n = 0; n < NUM_PROBES + NUM_RANDOM; n++)
        begin
            next_drive();
            r = $random(seed);
            if (n < NUM_PROBES)
            begin
                ox = probe_dx[n];
                oy = probe_dy[n];
            end
            else if (n % 2 == 0)
            begin
                ox = (r & 63) - 8;  // Near the marker.
                oy = ((r >>> 8) & 63) - 8;
            end
            else
            begin
                ox = (r & 1023) - ex;  // Anywhere on screen.
                oy = ((r >>> 10) & 1023) - ey;
            end
            boss_counter = `BOSS_W'(boss);
            draw_x       = coord_t'(ex + ox);
            draw_y       = coord_t'(ey + oy);
            #2;
            tag = $sformatf("level %0d boss %0d at (%0d,%0d)", lvl, boss, draw_x, draw_y);
            check_coord({tag, " exit_x_addr"}, coord_t'(ox), exit_x_addr);
            check_coord({tag, " exit_y_addr"}, coord_t'(oy), exit_y_addr);
            check_bit({tag, " is_exit"}, marker_hit(lvl, boss, ox, oy), is_exit);
        end
    endtask

    initial
    begin
        int s;
        int lvl;
        int k;
        rst_n        = 1'b0;
        restart      = 1'b0;
        level_done   = 1'b1;
        boss_counter = '0;
        draw_x       = '0;
        draw_y       = '0;
        block_idx    = '0;
        seed         = 32'hd87f;
        load_blocks();
        repeat (16) @(posedge Clk);
        #1;
        rst_n = 1'b1;
        verify_sequencer("after reset", 2'd0, 1'b1, 1'b0);

        for (s = 0; s < NUM_STEPS; s++)
        begin
            level_done = step_done[s];
            next_drive();
            verify_sequencer($sformatf("step %0d", s), step_level[s], step_update[s],
                             step_win[s]);
        end

        // Each pass restarts from wherever the previous one left the game.
        for (lvl = 0; lvl < `NUM_LEVELS; lvl++)
        begin
            pulse_restart();
            verify_sequencer($sformatf("restart before level %0d", lvl), 2'd0, 1'b1, 1'b0);
            for (k = 1; k <= lvl; k++)
                advance_level(level_idx_t'(k));
            verify_sequencer($sformatf("enter level %0d", lvl), level_idx_t'(lvl), 1'b1,
                             lvl == 3);
            test_level(lvl);
            probe_marker(lvl, 199);
            probe_marker(lvl, 200);
        end

        pulse_restart();
        verify_sequencer("restart from win", 2'd0, 1'b1, 1'b0);
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* map_assert.sv */
`default_nettype none
`timescale 1ns/1ps

module map_assert (
    input wire                       Clk,
    input wire                       rst_n,
    input wire                       restart,
    input wire game_pkg::level_idx_t level_idx,
    input wire                       update,
    input wire                       win
);
    import game_pkg::*;

    // The win screen is level 3.
    a_win_level: assert property (@(posedge Clk) disable iff (!rst_n)
        win |-> (level_idx == level_idx_t'(3)))
        else $error("win high while level_idx is %0d", level_idx);

    // Only reset or restart leaves the win screen.
    a_win_sticky: assert property (@(posedge Clk) disable iff (!rst_n)
        (win && !restart) |=> win)
        else $error("win dropped without reset or restart");

    a_update_win: assert property (@(posedge Clk) disable iff (!rst_n)
        (update && (level_idx == level_idx_t'(3))) |-> win)
        else $error("update on level 3 without win");  // Only win_arm reloads level 3.

endmodule

`default_nettype wire

/* map_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "map_defs.svh"

module map_top (
    input  wire                       Clk,
    input  wire                       rst_n,
    input  wire                       restart,
    input  wire                       level_done,
    input  wire [`BOSS_W-1:0]         boss_counter,
    input  wire geom_pkg::coord_t     draw_x,
    input  wire geom_pkg::coord_t     draw_y,
    input  wire geom_pkg::block_idx_t block_idx,
    output geom_pkg::coord_t          spawn_x,
    output geom_pkg::coord_t          spawn_y,
    output geom_pkg::coord_t          bullet_x,
    output geom_pkg::coord_t          bullet_y,
    output geom_pkg::coord_t          block_x,
    output geom_pkg::coord_t          block_y,
    output geom_pkg::coord_t          block_w,
    output geom_pkg::coord_t          block_h,
    output logic                      block_used,
    output geom_pkg::coord_t          exit_x_addr,
    output geom_pkg::coord_t          exit_y_addr,
    output logic                      is_exit,
    output game_pkg::level_idx_t      level_idx,
    output logic                      update,
    output logic                      win
);
    import geom_pkg::*;

    coord_t exit_x;  // Exit position of the current level.
    coord_t exit_y;

    level_sequencer u_sequencer (
        .Clk        (Clk),
        .rst_n      (rst_n),
        .restart    (restart),
        .level_done (level_done),
        .level_idx  (level_idx),
        .update     (update),
        .win        (win)
    );

    level_rom u_rom (
        .level_idx  (level_idx),
        .block_idx  (block_idx),
        .spawn_x    (spawn_x),
        .spawn_y    (spawn_y),
        .bullet_x   (bullet_x),
        .bullet_y   (bullet_y),
        .exit_x     (exit_x),
        .exit_y     (exit_y),
        .block_x    (block_x),
        .block_y    (block_y),
        .block_w    (block_w),
        .block_h    (block_h),
        .block_used (block_used)
    );

    exit_marker u_marker (
        .draw_x       (draw_x),
        .draw_y       (draw_y),
        .exit_x       (exit_x),
        .exit_y       (exit_y),
        .level_idx    (level_idx),
        .boss_counter (boss_counter),
        .exit_x_addr  (exit_x_addr),
        .exit_y_addr  (exit_y_addr),
        .is_exit      (is_exit)
    );

endmodule

`default_nettype wire

/* exit_marker.sv */
`default_nettype none
`timescale 1ns/1ps

`include "map_defs.svh"

module exit_marker (
    input  wire geom_pkg::coord_t     draw_x,
    input  wire geom_pkg::coord_t     draw_y,
    input  wire geom_pkg::coord_t     exit_x,
    input  wire geom_pkg::coord_t     exit_y,
    input  wire game_pkg::level_idx_t level_idx,
    input  wire [`BOSS_W-1:0]         boss_counter,
    output geom_pkg::coord_t          exit_x_addr,
    output geom_pkg::coord_t          exit_y_addr,
    output logic                      is_exit
);
    import geom_pkg::*;

    logic level_open;
    logic in_marker;

    // Sprite address wraps, so pixels left of or above the marker land out of range.
    assign exit_x_addr = draw_x - exit_x;
    assign exit_y_addr = draw_y - exit_y;

    // No exit on the win screen; level 2 exit waits for the boss.
    assign level_open = (level_idx != 2'd3) &&
                        ((level_idx != 2'd2) || (boss_counter >= `BOSS_W'(`BOSS_GATE)));

    assign in_marker = (exit_x_addr < coord_t'(`MARKER_W)) &&
                       (exit_y_addr < coord_t'(`MARKER_H));

    assign is_exit = level_open && in_marker;

endmodule

`default_nettype wire

/* level_rom.sv */
`default_nettype none
`timescale 1ns/1ps

`include "map_defs.svh"

module level_rom (
    input  wire game_pkg::level_idx_t level_idx,
    input  wire geom_pkg::block_idx_t block_idx,
    output geom_pkg::coord_t          spawn_x,
    output geom_pkg::coord_t          spawn_y,
    output geom_pkg::coord_t          bullet_x,
    output geom_pkg::coord_t          bullet_y,
    output geom_pkg::coord_t          exit_x,
    output geom_pkg::coord_t          exit_y,
    output geom_pkg::coord_t          block_x,
    output geom_pkg::coord_t          block_y,
    output geom_pkg::coord_t          block_w,
    output geom_pkg::coord_t          block_h,
    output logic                      block_used
);
    import geom_pkg::*;

    localparam int ENTRY_W = 4 * `COORD_W + 1;

    logic [ENTRY_W-1:0] entry;

    // Packs a used block as {used, x, y, w, h}.
    function automatic logic [ENTRY_W-1:0] make_block(input int x, input int y,
                                                       input int w, input int h);
        return {1'b1, coord_t'(x), coord_t'(y), coord_t'(w), coord_t'(h)};
    endfunction

    // Player and bullet spawn points.
    always_comb
    begin
        spawn_x  = coord_t'(20);
        spawn_y  = coord_t'(380);
        bullet_x = coord_t'(20);
        bullet_y = coord_t'(380);
        if (level_idx == 2'd2)
        begin
            spawn_x  = coord_t'(30);
            spawn_y  = coord_t'(300);
            bullet_x = coord_t'(600);  // Bullet starts on the far side.
            bullet_y = coord_t'(300);
        end
    end

    always_comb
    begin
        case (level_idx)
            2'd0:
            begin
                exit_x = coord_t'(620);
                exit_y = coord_t'(310);
            end
            2'd1:
            begin
                exit_x = coord_t'(620);
                exit_y = coord_t'(40);
            end
            2'd2:
            begin
                exit_x = coord_t'(600);
                exit_y = coord_t'(375);
            end
            default:
            begin
                exit_x = coord_t'(330);
                exit_y = coord_t'(450);
            end
        endcase
    end

    // Unlisted entries and out of range indexes read as unused zeros.
    always_comb
    begin
        entry = '0;
        case (level_idx)
            2'd0:
                case (block_idx)
                    5'd1:    entry = make_block(480, 340, 160, 140);
                    5'd2:    entry = make_block(320, 360, 160, 120);
                    5'd3:    entry = make_block(160, 380, 160, 100);
                    5'd4:    entry = make_block(0, 400, 160, 80);
                    default: entry = '0;
                endcase
            2'd1:
                case (block_idx)
                    5'd0:    entry = make_block(0, 0, 640, 20);
                    5'd1:    entry = make_block(0, 20, 20, 280);
                    5'd2:    entry = make_block(280, 60, 240, 20);
                    5'd3:    entry = make_block(140, 80, 120, 20);
                    5'd4:    entry = make_block(560, 80, 100, 20);
                    5'd5:    entry = make_block(620, 100, 20, 380);
                    5'd6:    entry = make_block(20, 160, 60, 60);
                    5'd7:    entry = make_block(80, 160, 180, 100);
                    5'd8:    entry = make_block(500, 220, 100, 20);
                    5'd9:    entry = make_block(260, 240, 240, 20);
                    5'd10:   entry = make_block(540, 320, 80, 160);
                    5'd11:   entry = make_block(0, 340, 140, 20);
                    5'd12:   entry = make_block(220, 340, 80, 100);
                    5'd13:   entry = make_block(400, 380, 100, 20);
                    5'd14:   entry = make_block(0, 440, 300, 40);
                    default: entry = '0;
                endcase
            2'd2:
                case (block_idx)
                    5'd0:    entry = make_block(100, 100, 150, 40);
                    5'd1:    entry = make_block(100, 200, 150, 40);
                    5'd2:    entry = make_block(100, 300, 150, 40);
                    5'd3:    entry = make_block(300, 200, 150, 40);
                    5'd4:    entry = make_block(0, 400, 640, 80);  // Floor.
                    default: entry = '0;
                endcase
            default:
                case (block_idx)
                    5'd0:    entry = make_block(160, 360, 320, 40);
                    5'd1:    entry = make_block(240, 320, 160, 40);
                    5'd2:    entry = make_block(300, 280, 40, 40);
                    5'd4:    entry = make_block(0, 400, 640, 80);
                    default: entry = '0;
                endcase
        endcase
    end

    assign {block_used, block_x, block_y, block_w, block_h} = entry;

endmodule

`default_nettype wire

/* level_sequencer.sv */
`default_nettype none
`timescale 1ns/1ps

module level_sequencer (
    input  wire                  Clk,
    input  wire                  rst_n,
    input  wire                  restart,
    input  wire                  level_done,
    output game_pkg::level_idx_t level_idx,
    output logic                 update,
    output logic                 win
);
    import game_pkg::*;

    level_state_e state;
    level_state_e next_state;

    // Restart key behaves like reset.
    always_ff @(posedge Clk)
    begin
        if (!rst_n || restart)
        begin
            state <= lvl0_arm;
        end
        else
        begin
            state <= next_state;
        end
    end

    // A level only advances after level_done was low and then high.
    always_comb
    begin
        next_state = state;
        case (state)
            lvl0_arm:
                if (!level_done)
                    next_state = lvl0_run;
            lvl0_run:
                if (level_done)
                    next_state = lvl1_arm;
            lvl1_arm:
                if (!level_done)
                    next_state = lvl1_run;
            lvl1_run:
                if (level_done)
                    next_state = lvl2_arm;
            lvl2_arm:
                if (!level_done)
                    next_state = lvl2_run;
            lvl2_run:
                if (level_done)
                    next_state = win_arm;
            win_arm:
                next_state = win_hold;
            win_hold:
                next_state = win_hold;  // Left only by reset or restart.
            default:
                next_state = lvl0_arm;
        endcase
    end

    always_comb
    begin
        level_idx = level_idx_t'(0);
        case (state)
            lvl1_arm, lvl1_run:
                level_idx = level_idx_t'(1);
            lvl2_arm, lvl2_run:
                level_idx = level_idx_t'(2);
            win_arm, win_hold:
                level_idx = level_idx_t'(3);
            default:
                level_idx = level_idx_t'(0);
        endcase
    end

    assign update = state inside {lvl0_arm, lvl1_arm, lvl2_arm, win_arm};  // Reload spawn points.
    assign win    = state inside {win_arm, win_hold};

endmodule

`default_nettype wire

/* geom_pkg.sv */
`default_nettype none

`include "map_defs.svh"

package geom_pkg;

    // Pixel position or size on screen.
    typedef logic [`COORD_W-1:0] coord_t;

    // Index into the per-level block table.
    typedef logic [$clog2(`NUM_BLOCKS)-1:0] block_idx_t;

endpackage

`default_nettype wire

/* game_pkg.sv */
`default_nettype none

`include "map_defs.svh"

package game_pkg;

    // Arm states wait for level_done low, run states wait for it high.
    typedef enum logic [2:0] {
        lvl0_arm = 3'd0,
        lvl0_run = 3'd1,
        lvl1_arm = 3'd2,
        lvl1_run = 3'd3,
        lvl2_arm = 3'd4,
        lvl2_run = 3'd5,
        win_arm  = 3'd6,
        win_hold = 3'd7
    } level_state_e;

    typedef logic [$clog2(`NUM_LEVELS)-1:0] level_idx_t;  // Level 3 is the win screen.

endpackage

`default_nettype wire

/* map_defs.svh */
`ifndef MAP_DEFS_SVH
`define MAP_DEFS_SVH

// Screen coordinates and block sizes.
`define COORD_W     10

// Level table dimensions.
`define NUM_BLOCKS  17
`define NUM_LEVELS  4

// Exit marker sprite, in pixels.
`define MARKER_W    17
`define MARKER_H    24

// Level 2 exit stays hidden until the boss counter reaches this value.
`define BOSS_GATE   200
`define BOSS_W      9

`endif
